/* rtl/exec_macros.svh */
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// Operand, result and branch target width
`define EXEC_DATA_W 32

// Pointer adjust lanes, feeding results 2 to 4
`define EXEC_NUM_LANES 3

// ALU result plus one per lane
`define EXEC_NUM_RES (`EXEC_NUM_LANES + 1)

// Operand size code width (byte, word, dword)
`define EXEC_OPSIZE_W 2

// Opcode field width
`define EXEC_OP_W 4

// Lane action field width
`define EXEC_LANE_MODE_W 2

`endif

/* rtl/exec_flags_pkg.sv */
`include "exec_macros.svh"

package exec_flags_pkg;

    // Architectural flags kept by the stage
    typedef struct packed {
        logic cf;   // Carry
        logic zf;   // Zero
        logic sf;   // Sign
        logic df;   // Direction, used by MOVS
    } eflags_t;

    // JCC condition select
    typedef enum logic [1:0] {
        cond_always = 2'd0,
        cond_carry  = 2'd1,
        cond_zero   = 2'd2,
        cond_none   = 2'd3   // Never taken
    } br_cond_e;

    // Branch resolution sent back to fetch
    typedef struct packed {
        logic                    valid;
        logic                    taken;
        logic                    correct;  // Prediction matched
        logic [`EXEC_DATA_W-1:0] target;   // Next fetch address
    } br_result_t;

endpackage

/* rtl/exec_types_pkg.sv */
`include "exec_macros.svh"

package exec_types_pkg;

    // Micro-op codes handled by this stage
    typedef enum logic [`EXEC_OP_W-1:0] {
        op_add, op_and, op_or, op_not, op_mov,
        op_cmovc, op_xchg, op_movs, op_push, op_pop,
        op_jcc, op_cld, op_std
    } exec_op_e;

    // Decoded micro-op
    typedef struct packed {
        exec_op_e                  op;
        logic [`EXEC_OPSIZE_W-1:0] opsize;      // 0 byte, 1 word, 2 dword
        exec_flags_pkg::br_cond_e  cond;        // JCC only
        logic                      pred_taken;
        logic [`EXEC_DATA_W-1:0]   pred_target;
    } exec_uop_t;

    typedef struct packed {
        logic [`EXEC_DATA_W-1:0] op1;
        logic [`EXEC_DATA_W-1:0] op2;
        logic [`EXEC_DATA_W-1:0] op3;
        logic [`EXEC_DATA_W-1:0] op4;
    } exec_operands_t;

    typedef enum logic [`EXEC_LANE_MODE_W-1:0] {
        lane_pass, lane_add_step, lane_sub_step, lane_replace
    } lane_mode_e;

    typedef struct packed {
        lane_mode_e              mode;
        logic [`EXEC_DATA_W-1:0] repl;  // Used by lane_replace
    } lane_ctrl_t;

    // Index 0 is result 1 (ALU), 1..3 are the lanes
    typedef struct packed {
        logic [`EXEC_NUM_RES-1:0][`EXEC_DATA_W-1:0] res;
        logic [`EXEC_NUM_RES-1:0]                   we;
    } exec_result_t;

endpackage

/* rtl/exec_uop_decode.sv */
`timescale 1ns/100ps
`include "exec_macros.svh"

module exec_uop_decode (
    input  exec_types_pkg::exec_uop_t                          uop,
    input  exec_types_pkg::exec_operands_t                     ops,
    input  exec_flags_pkg::eflags_t                            flags,
    output exec_types_pkg::exec_op_e                           alu_op,
    output exec_types_pkg::lane_ctrl_t [`EXEC_NUM_LANES-1:0]   lane_ctrl,
    output exec_flags_pkg::eflags_t                            flag_we,
    output logic                                               skip,
    output logic [`EXEC_NUM_RES-1:0]                           wb_mask
);

    exec_types_pkg::lane_mode_e movs_dir;

    // MOVS walks down when df is set
    assign movs_dir = flags.df ? exec_types_pkg::lane_sub_step : exec_types_pkg::lane_add_step;

    always_comb begin
        alu_op     = uop.op;
        flag_we    = '0;
        skip       = 1'b0;
        wb_mask    = '0;
        wb_mask[0] = 1'b1;   // Most ops write result 1
        for (int i = 0; i < `EXEC_NUM_LANES; i++) begin
            lane_ctrl[i].mode = exec_types_pkg::lane_pass;
            lane_ctrl[i].repl = '0;
        end

        case (uop.op)
            exec_types_pkg::op_add,
            exec_types_pkg::op_and,
            exec_types_pkg::op_or: begin
                flag_we.cf = 1'b1;
                flag_we.zf = 1'b1;
                flag_we.sf = 1'b1;
            end
            exec_types_pkg::op_cmovc: skip = ~flags.cf;   // Move only on carry
            exec_types_pkg::op_xchg: begin
                lane_ctrl[0].mode = exec_types_pkg::lane_replace;   // op2 <- op1
                lane_ctrl[0].repl = ops.op1;
            end
            exec_types_pkg::op_movs: begin
                lane_ctrl[0].mode = movs_dir;   // Source index
                lane_ctrl[1].mode = movs_dir;   // Destination index
            end
            exec_types_pkg::op_push: lane_ctrl[2].mode = exec_types_pkg::lane_sub_step;
            exec_types_pkg::op_pop:  lane_ctrl[2].mode = exec_types_pkg::lane_add_step;
            exec_types_pkg::op_jcc:  wb_mask[0] = 1'b0;
            exec_types_pkg::op_cld,
            exec_types_pkg::op_std: begin
                flag_we.df = 1'b1;
                wb_mask[0] = 1'b0;
            end
            default: ;
        endcase

        // Lanes write back only when they change
        for (int i = 0; i < `EXEC_NUM_LANES; i++) begin
            wb_mask[i+1] = (lane_ctrl[i].mode != exec_types_pkg::lane_pass);
        end
    end

    always_comb begin
        if (!$isunknown(uop.op)) begin
            op_legal_a: assert (uop.op <= exec_types_pkg::op_std)
                else $error("exec_uop_decode: illegal op %0d", uop.op);
        end
    end

endmodule

/* rtl/exec_alu.sv */
`timescale 1ns/100ps
`include "exec_macros.svh"

module exec_alu (
    input  exec_types_pkg::exec_op_e         alu_op,
    input  logic [`EXEC_OPSIZE_W-1:0]        opsize,
    input  logic [`EXEC_DATA_W-1:0]          op1,
    input  logic [`EXEC_DATA_W-1:0]          op2,
    output logic [`EXEC_DATA_W-1:0]          result,
    output exec_flags_pkg::eflags_t          flags_new
);

    logic [`EXEC_DATA_W:0] sum;   // Extra bit is the carry out

    assign sum = {1'b0, op1} + {1'b0, op2};

    always_comb begin
        result    = '0;
        flags_new = '0;

        case (alu_op)
            exec_types_pkg::op_add: begin
                result       = sum[`EXEC_DATA_W-1:0];
                flags_new.cf = sum[`EXEC_DATA_W];
            end
            exec_types_pkg::op_and: result = op1 & op2;   // cf stays 0
            exec_types_pkg::op_or:  result = op1 | op2;
            exec_types_pkg::op_not: result = ~op1;
            exec_types_pkg::op_mov,
            exec_types_pkg::op_cmovc,
            exec_types_pkg::op_xchg: result = op2;
            exec_types_pkg::op_movs,
            exec_types_pkg::op_push,
            exec_types_pkg::op_pop: result = op1;

            // JCC, CLD and STD leave result 1 unwritten
            default: result = '0;
        endcase

        // Full width flags, masked later by flag_we
        flags_new.zf = (result == '0);
        flags_new.sf = result[`EXEC_DATA_W-1];
        flags_new.df = (alu_op == exec_types_pkg::op_std);
    end

    always_comb begin
        if (alu_op inside {exec_types_pkg::op_add, exec_types_pkg::op_and,
                           exec_types_pkg::op_or}) begin
            alu_size_a: assert ($isunknown(opsize) || opsize != 2'd3)
                else $error("exec_alu: reserved opsize on flag-setting op");
        end
    end

endmodule

/* rtl/ptr_adjust_lane.sv */
`timescale 1ns/100ps
`include "exec_macros.svh"

module ptr_adjust_lane (
    input  logic [`EXEC_OPSIZE_W-1:0]    opsize,
    input  logic [`EXEC_DATA_W-1:0]      operand,
    input  exec_types_pkg::lane_ctrl_t   ctrl,
    output logic [`EXEC_DATA_W-1:0]      result
);

    logic [`EXEC_DATA_W-1:0] step;

    // Byte, word, dword
    always_comb begin
        case (opsize)
            2'd0:    step = `EXEC_DATA_W'd1;
            2'd1:    step = `EXEC_DATA_W'd2;
            2'd2:    step = `EXEC_DATA_W'd4;
            default: step = '0;
        endcase
    end

    always_comb begin
        case (ctrl.mode)
            exec_types_pkg::lane_add_step: result = operand + step;
            exec_types_pkg::lane_sub_step: result = operand - step;
            exec_types_pkg::lane_replace:  result = ctrl.repl;   // XCHG
            default:                       result = operand;
        endcase
    end

    always_comb begin
        if (ctrl.mode inside {exec_types_pkg::lane_add_step,
                              exec_types_pkg::lane_sub_step}) begin
            step_size_a: assert ($isunknown(opsize) || opsize != 2'd3)
                else $error("ptr_adjust_lane: step with reserved opsize");
        end
    end

endmodule

/* rtl/exec_retire.sv */
`timescale 1ns/100ps
`include "exec_macros.svh"

module exec_retire (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              valid_in,
    input  logic                              stall,
    input  logic                              skip,
    input  exec_types_pkg::exec_result_t      result_c,
    input  exec_flags_pkg::eflags_t           flags_new,
    input  exec_flags_pkg::eflags_t           flag_we,
    input  exec_flags_pkg::br_cond_e          cond,
    input  logic                              pred_taken,
    input  logic [`EXEC_DATA_W-1:0]           pred_target,
    input  logic [`EXEC_DATA_W-1:0]           branch_target,
    input  logic [`EXEC_DATA_W-1:0]           next_eip,
    input  logic                              is_jcc,
    output exec_flags_pkg::eflags_t           flags,
    output logic                              valid_out,
    output exec_types_pkg::exec_result_t      result,
    output exec_flags_pkg::br_result_t        br
);

    logic accept;
    logic taken_c;
    logic correct_c;
    logic [`EXEC_DATA_W-1:0] target_c;

    exec_flags_pkg::eflags_t flags_q;
    logic                    valid_q;
    logic                    br_valid_q;
    logic [`EXEC_NUM_RES-1:0] we_q;
    logic [`EXEC_NUM_RES-1:0][`EXEC_DATA_W-1:0] data_q;
    logic                    br_taken_q;
    logic                    br_correct_q;
    logic [`EXEC_DATA_W-1:0] br_target_q;

    assign accept = valid_in & ~stall;

    // Branch resolves against flags from before this micro-op
    always_comb begin
        case (cond)
            exec_flags_pkg::cond_always: taken_c = 1'b1;
            exec_flags_pkg::cond_carry:  taken_c = flags_q.cf;
            exec_flags_pkg::cond_zero:   taken_c = flags_q.zf;
            default:                     taken_c = 1'b0;
        endcase
    end

    assign target_c  = taken_c ? branch_target : next_eip;
    assign correct_c = (pred_taken == taken_c) && (!taken_c || pred_target == branch_target);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flags_q    <= '0;
            valid_q    <= 1'b0;
            br_valid_q <= 1'b0;
            we_q       <= '0;
        end else begin
            valid_q    <= accept & ~skip;   // Low during stall so nothing repeats
            br_valid_q <= accept & is_jcc;
            we_q       <= (accept & ~skip) ? result_c.we : '0;
            if (accept) begin
                flags_q <= (flags_q & ~flag_we) | (flags_new & flag_we);
            end
        end
    end

    // Payload held across stalls
    always_ff @(posedge clk) begin
        if (accept) begin
            data_q       <= result_c.res;
            br_taken_q   <= taken_c;
            br_correct_q <= correct_c;
            br_target_q  <= target_c;
        end
    end

    assign flags      = flags_q;
    assign valid_out  = valid_q;
    assign result.res = data_q;
    assign result.we  = we_q;
    assign br.valid   = br_valid_q;
    assign br.taken   = br_taken_q;
    assign br.correct = br_correct_q;
    assign br.target  = br_target_q;

    br_needs_valid_a: assert property (@(posedge clk) disable iff (!rst_n)
        br.valid |-> valid_out);

endmodule

/* rtl/exec_stage_top.sv */
`timescale 1ns/100ps
`include "exec_macros.svh"

module exec_stage_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            valid_in,
    input  logic                            stall,
    input  exec_types_pkg::exec_uop_t       uop,
    input  exec_types_pkg::exec_operands_t  ops,
    input  logic [`EXEC_DATA_W-1:0]         next_eip,
    output logic                            valid_out,
    output exec_types_pkg::exec_result_t    result,
    output exec_flags_pkg::eflags_t         flags,
    output exec_flags_pkg::br_result_t      br
);

    exec_types_pkg::exec_op_e                          alu_op;
    exec_types_pkg::lane_ctrl_t [`EXEC_NUM_LANES-1:0]  lane_ctrl;
    exec_flags_pkg::eflags_t                           flag_we;
    exec_flags_pkg::eflags_t                           flags_new;
    logic                                              skip;
    logic [`EXEC_NUM_RES-1:0]                          wb_mask;
    logic [`EXEC_DATA_W-1:0]                           alu_res;
    logic [`EXEC_NUM_LANES-1:0][`EXEC_DATA_W-1:0]      lane_in;
    logic [`EXEC_NUM_LANES-1:0][`EXEC_DATA_W-1:0]      lane_res;
    exec_types_pkg::exec_result_t                      result_c;

    exec_uop_decode u_decode (
        .uop(uop), .ops(ops), .flags(flags), .alu_op(alu_op),
        .lane_ctrl(lane_ctrl), .flag_we(flag_we), .skip(skip), .wb_mask(wb_mask)
    );

    exec_alu u_alu (
        .alu_op(alu_op), .opsize(uop.opsize), .op1(ops.op1), .op2(ops.op2),
        .result(alu_res), .flags_new(flags_new)
    );

    assign lane_in = {ops.op4, ops.op3, ops.op2};   // Lane 0 takes op2

    for (genvar i = 0; i < `EXEC_NUM_LANES; i++) begin : g_lane
        ptr_adjust_lane u_lane (
            .opsize(uop.opsize), .operand(lane_in[i]),
            .ctrl(lane_ctrl[i]), .result(lane_res[i])
        );
    end

    assign result_c.res = {lane_res, alu_res};   // res[0] is the ALU
    assign result_c.we  = wb_mask;

    exec_retire u_retire (
        .clk(clk), .rst_n(rst_n), .valid_in(valid_in), .stall(stall), .skip(skip),
        .result_c(result_c), .flags_new(flags_new), .flag_we(flag_we),
        .cond(uop.cond), .pred_taken(uop.pred_taken), .pred_target(uop.pred_target),
        .branch_target(ops.op1), .next_eip(next_eip),
        .is_jcc(uop.op == exec_types_pkg::op_jcc),
        .flags(flags), .valid_out(valid_out), .result(result), .br(br)
    );

endmodule

/* tb/exec_stage_tb.sv */
`timescale 1ns/100ps
`include "exec_macros.svh"

module exec_stage_tb;

    typedef struct packed {
        exec_types_pkg::exec_result_t res;
        exec_flags_pkg::eflags_t      flags;   // Flags after this micro-op
        exec_flags_pkg::br_result_t   br;
        logic                         skip;    // CMOVC without carry
    } expect_t;

    logic                           clk;
    logic                           rst_n;
    logic                           valid_in;
    logic                           stall;
    exec_types_pkg::exec_uop_t      uop;
    exec_types_pkg::exec_operands_t ops;
    logic [`EXEC_DATA_W-1:0]        next_eip;
    logic                           valid_out;
    exec_types_pkg::exec_result_t   result;
    exec_flags_pkg::eflags_t        flags;
    exec_flags_pkg::br_result_t     br;

    expect_t                 exp_q[$];
    expect_t                 exp_rec;
    exec_flags_pkg::eflags_t model_flags;     // After the last issued micro-op
    exec_flags_pkg::eflags_t retired_flags;   // After the last checked pulse
    int                      errors;
    int                      checks;

    exec_stage_top dut (
        .clk(clk), .rst_n(rst_n), .valid_in(valid_in), .stall(stall), .uop(uop),
        .ops(ops), .next_eip(next_eip), .valid_out(valid_out), .result(result),
        .flags(flags), .br(br)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic expect_t exec_model(input exec_types_pkg::exec_uop_t u,
                                           input exec_types_pkg::exec_operands_t o,
                                           input logic [31:0] neip,
                                           input exec_flags_pkg::eflags_t f_in);
        expect_t     e;
        logic [32:0] sum;
        logic [31:0] step;
        logic        taken;
        e = '0;
        e.flags = f_in;
        step = (u.opsize == 2'd0) ? 32'd1 : (u.opsize == 2'd1) ? 32'd2 : 32'd4;
        sum = {1'b0, o.op1} + {1'b0, o.op2};
        case (u.op)
            exec_types_pkg::op_add: e.res.res[0] = sum[31:0];
            exec_types_pkg::op_and: e.res.res[0] = o.op1 & o.op2;
            exec_types_pkg::op_or:  e.res.res[0] = o.op1 | o.op2;
            exec_types_pkg::op_not: e.res.res[0] = ~o.op1;
            exec_types_pkg::op_mov,
            exec_types_pkg::op_cmovc,
            exec_types_pkg::op_xchg: e.res.res[0] = o.op2;
            default: e.res.res[0] = o.op1;   // MOVS, PUSH, POP
        endcase
        e.res.we[0] = !(u.op inside {exec_types_pkg::op_jcc, exec_types_pkg::op_cld,
                                     exec_types_pkg::op_std});
        if (u.op inside {exec_types_pkg::op_add, exec_types_pkg::op_and,
                         exec_types_pkg::op_or}) begin
            e.flags.cf = (u.op == exec_types_pkg::op_add) ? sum[32] : 1'b0;
            e.flags.zf = (e.res.res[0] == 32'd0);
            e.flags.sf = e.res.res[0][31];
        end
        case (u.op)
            exec_types_pkg::op_cmovc: e.skip = !f_in.cf;
            exec_types_pkg::op_xchg: begin
                e.res.res[1] = o.op1;
                e.res.we[1]  = 1'b1;
            end
            exec_types_pkg::op_movs: begin
                e.res.res[1]   = f_in.df ? o.op2 - step : o.op2 + step;   // Source
                e.res.res[2]   = f_in.df ? o.op3 - step : o.op3 + step;   // Destination
                e.res.we[2:1]  = 2'b11;
            end
            exec_types_pkg::op_push: begin
                e.res.res[3] = o.op4 - step;
                e.res.we[3]  = 1'b1;
            end
            exec_types_pkg::op_pop: begin
                e.res.res[3] = o.op4 + step;
                e.res.we[3]  = 1'b1;
            end
            exec_types_pkg::op_cld: e.flags.df = 1'b0;
            exec_types_pkg::op_std: e.flags.df = 1'b1;
            exec_types_pkg::op_jcc: begin
                case (u.cond)
                    exec_flags_pkg::cond_always: taken = 1'b1;
                    exec_flags_pkg::cond_carry:  taken = f_in.cf;
                    exec_flags_pkg::cond_zero:   taken = f_in.zf;
                    default:                     taken = 1'b0;
                endcase
                e.br.valid   = 1'b1;
                e.br.taken   = taken;
                e.br.target  = taken ? o.op1 : neip;
                e.br.correct = (u.pred_taken == taken) && (!taken || u.pred_target == o.op1);
            end
            default: ;
        endcase
        return e;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        value_a: assert (act === exp)
            else begin
                errors++;
                $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, exp, act);
            end
    endtask

    function automatic logic random_stall();
        return ($urandom % 4) == 0;   // About one cycle in four
    endfunction

    function automatic exec_types_pkg::exec_operands_t rand_ops();
        exec_types_pkg::exec_operands_t o;
        o.op1 = $urandom;
        o.op2 = $urandom;
        o.op3 = $urandom;
        o.op4 = $urandom;
        return o;
    endfunction

    // Holds the micro-op on the inputs until a cycle without stall
    task automatic issue(input exec_types_pkg::exec_op_e op, input logic [1:0] size,
                         input exec_flags_pkg::br_cond_e cond, input logic pt,
                         input logic [31:0] ptgt, input exec_types_pkg::exec_operands_t o);
        int      guard;
        expect_t e;
        @(negedge clk);
        uop.op          = op;
        uop.opsize      = size;
        uop.cond        = cond;
        uop.pred_taken  = pt;
        uop.pred_target = ptgt;
        ops             = o;
        next_eip        = $urandom;
        valid_in        = 1'b1;
        stall           = random_stall();
        guard           = 0;
        while (stall) begin
            @(negedge clk);
            guard++;
            stall = (guard < 8) ? random_stall() : 1'b0;
        end
        e = exec_model(uop, ops, next_eip, model_flags);
        if (!e.skip) begin
            exp_q.push_back(e);
        end
        model_flags = e.flags;
    endtask

    task automatic issue_op(input exec_types_pkg::exec_op_e op, input logic [1:0] size,
                            input exec_types_pkg::exec_operands_t o);
        issue(op, size, exec_flags_pkg::cond_none, 1'b0, 32'd0, o);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            valid_in = 1'b0;
            stall    = random_stall();
        end
    endtask

    always @(posedge clk) begin
        if (rst_n && (valid_out || br.valid)) begin
            pending_a: assert (exp_q.size() != 0)
                else begin
                    errors++;
                    $display("Output pulse at %0t with no micro-op outstanding", $time);
                end
            if (exp_q.size() != 0) begin
                exp_rec = exp_q.pop_front();
                check_value("valid_out", 32'd1, {31'd0, valid_out});
                check_value("br.valid", {31'd0, exp_rec.br.valid}, {31'd0, br.valid});
                check_value("result.we", {28'd0, exp_rec.res.we}, {28'd0, result.we});
                for (int i = 0; i < `EXEC_NUM_RES; i++) begin
                    if (exp_rec.res.we[i]) begin
                        check_value($sformatf("result.res[%0d]", i), exp_rec.res.res[i],
                                    result.res[i]);
                    end
                end
                check_value("flags", {28'd0, exp_rec.flags}, {28'd0, flags});
                if (exp_rec.br.valid) begin
                    check_value("br.taken", {31'd0, exp_rec.br.taken}, {31'd0, br.taken});
                    check_value("br.correct", {31'd0, exp_rec.br.correct}, {31'd0, br.correct});
                    check_value("br.target", exp_rec.br.target, br.target);
                end
                retired_flags = exp_rec.flags;
            end
        end else if (rst_n) begin
            check_value("flags", {28'd0, retired_flags}, {28'd0, flags});   // Held when idle
            check_value("result.we", 32'd0, {28'd0, result.we});
        end
    end

    initial begin
        int                             k;
        int                             wait_cycles;
        exec_types_pkg::exec_operands_t o;
        void'($urandom(32'hd8af_cde7));
        errors = 0;
        checks = 0;
        rst_n = 1'b0;
        valid_in = 1'b0;
        stall = 1'b0;
        uop = '0;
        ops = '0;
        next_eip = '0;
        model_flags = '0;
        retired_flags = '0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        check_value("valid_out", 32'd0, {31'd0, valid_out});
        check_value("br.valid", 32'd0, {31'd0, br.valid});
        check_value("result.we", 32'd0, {28'd0, result.we});
        check_value("flags", 32'd0, {28'd0, flags});

        for (k = 0; k < 40; k++) begin   // ADD, AND, OR, NOT, MOV
            issue_op(exec_types_pkg::exec_op_e'(4'($urandom % 5)), 2'($urandom % 3), rand_ops());
        end
        for (k = 0; k < 6; k++) begin
            issue_op((k < 3) ? exec_types_pkg::op_cld : exec_types_pkg::op_std, 2'd0, rand_ops());
            issue_op(exec_types_pkg::op_movs, 2'(k % 3), rand_ops());
        end
        for (k = 0; k < 6; k++) begin
            issue_op((k % 2) ? exec_types_pkg::op_pop : exec_types_pkg::op_push, 2'(k / 2),
                     rand_ops());
        end
        repeat (3) issue_op(exec_types_pkg::op_xchg, 2'd2, rand_ops());

        // Carry set, then carry cleared
        o = rand_ops();
        o.op1 = 32'hffff_fff0;
        o.op2 = 32'h0000_0020;
        issue_op(exec_types_pkg::op_add, 2'd2, o);
        issue_op(exec_types_pkg::op_cmovc, 2'd2, rand_ops());
        issue_op(exec_types_pkg::op_and, 2'd2, o);
        issue_op(exec_types_pkg::op_cmovc, 2'd2, rand_ops());

        for (k = 0; k < 40; k++) begin
            if ($urandom % 2) begin
                issue_op(exec_types_pkg::exec_op_e'(4'($urandom % 3)), 2'd2, rand_ops());
            end
            o = rand_ops();
            issue(exec_types_pkg::op_jcc, 2'd2, exec_flags_pkg::br_cond_e'(2'($urandom % 4)),
                  1'($urandom % 2), ($urandom % 2) ? o.op1 : $urandom, o);
        end
        for (k = 0; k < 60; k++) begin
            issue(exec_types_pkg::exec_op_e'(4'($urandom % 13)), 2'($urandom % 3),
                  exec_flags_pkg::br_cond_e'(2'($urandom % 4)), 1'($urandom % 2), $urandom,
                  rand_ops());
            if ($urandom % 3 == 0) begin
                idle(int'($urandom % 3) + 1);
            end
        end
        idle(2);

        wait_cycles = 0;
        while (exp_q.size() != 0 && wait_cycles < 20) begin
            @(negedge clk);
            wait_cycles++;
        end
        drain_a: assert (exp_q.size() == 0)
            else begin
                errors++;
                $display("Timed out with %0d results never seen on valid_out", exp_q.size());
            end
        $display("errors=%0d checks=%0d", errors, checks);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+rtl
rtl/exec_flags_pkg.sv
rtl/exec_types_pkg.sv
rtl/exec_uop_decode.sv
rtl/exec_alu.sv
rtl/ptr_adjust_lane.sv
rtl/exec_retire.sv
rtl/exec_stage_top.sv
tb/exec_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module exec_stage_tb \
    --Mdir obj_dir -o exec_stage_sim

./obj_dir/exec_stage_sim | tee sim.log

if grep -q "test failed" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
if ! grep -q "test passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
